// ==== project.f ====
+incdir+common
common/xif_pkg.sv
copro/copro_decoder.sv
copro/copro_alu.sv
copro/xif_coprocessor.sv
hdl/offload_unit.sv
hdl/cpu_subsys.sv
test/cpu_subsys_properties.sv
test/cpu_subsys_tb.sv

// ==== test/cpu_subsys_tb.sv ====
`timescale 1ns/1ps

`include "xif_defs.svh"

module cpu_subsys_tb;

  localparam int TIMEOUT_CYCLES = 50;

  typedef struct {
    string                name;
    logic [31:0]          instr;
    logic [`XIF_XLEN-1:0] rs1;
    logic [`XIF_XLEN-1:0] rs2;
    int                   hold;
  } test_entry_t;

  logic               clk;
  logic               rst_n;
  logic               host_req;
  xif_pkg::host_req_t host_req_data;
  logic               host_ack;
  xif_pkg::host_rsp_t host_rsp;

  test_entry_t tests[$];
  integer      seed;
  int          errors;
  int          run_count;
  int          pass_count;
  bit          timed_out;

  cpu_subsys i_cpu_subsys (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .host_req_i      ( host_req      ),
    .host_req_data_i ( host_req_data ),
    .host_ack_o      ( host_ack      ),
    .host_rsp_o      ( host_rsp      )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [6:0] opc);
    return {imm, 5'd1, f3, 5'd3, opc};
  endfunction

  // Expected answer straight from the instruction encoding rules
  function automatic xif_pkg::host_rsp_t ref_model(input logic [31:0] instr,
                                                   input logic [`XIF_XLEN-1:0] a,
                                                   input logic [`XIF_XLEN-1:0] b);
    xif_pkg::host_rsp_t   rsp;
    logic [`XIF_XLEN-1:0] imm_sx;
    rsp.result  = '0;
    rsp.illegal = 1'b1;
    imm_sx      = {{(`XIF_XLEN-12){instr[31]}}, instr[31:20]};
    if (`XIF_COPRO_EN == 1'b0) begin
      return rsp;
    end
    if (instr[6:0] == `XIF_OPC_CUSTOM0 && instr[31:25] == 7'd0 && instr[14:12] < 3'd4) begin
      rsp.illegal = 1'b0;
      case (instr[14:12])
        3'd0: rsp.result = a + b;
        3'd1: rsp.result = a - b;
        3'd2: rsp.result = a ^ b;
        default: rsp.result = (a < b) ? a : b;
      endcase
    end else if (instr[6:0] == `XIF_OPC_CUSTOM1 && instr[14:12] == 3'd0) begin
      rsp.illegal = 1'b0;
      rsp.result  = a + imm_sx;
    end else if (instr[6:0] == `XIF_OPC_CUSTOM1 && instr[14:12] == 3'd1 &&
                 instr[31:25] == 7'd0) begin
      rsp.illegal = 1'b0;
      rsp.result  = a << instr[24:20];
    end
    return rsp;
  endfunction

  task automatic add_test(input string name, input logic [31:0] instr,
                          input logic [31:0] a, input logic [31:0] b, input int hold);
    test_entry_t t;
    t.name  = name;
    t.instr = instr;
    t.rs1   = a;
    t.rs2   = b;
    t.hold  = hold;
    tests.push_back(t);
  endtask

  task automatic build_table();
    logic [31:0] word;
    add_test("add", enc_r(7'd0, 3'd0, `XIF_OPC_CUSTOM0), 32'd5, 32'd7, 0);
    add_test("add_wrap", enc_r(7'd0, 3'd0, `XIF_OPC_CUSTOM0), 32'hffff_ffff, 32'd2, 0);
    add_test("sub", enc_r(7'd0, 3'd1, `XIF_OPC_CUSTOM0), 32'd10, 32'd3, 0);
    add_test("sub_wrap", enc_r(7'd0, 3'd1, `XIF_OPC_CUSTOM0), 32'd3, 32'd10, 0);
    add_test("xor", enc_r(7'd0, 3'd2, `XIF_OPC_CUSTOM0), 32'hf0f0_1234, 32'h0ff0_ffff, 0);
    add_test("minu_big", enc_r(7'd0, 3'd3, `XIF_OPC_CUSTOM0), 32'h8000_0000, 32'd5, 0);
    add_test("minu_small", enc_r(7'd0, 3'd3, `XIF_OPC_CUSTOM0), 32'd9, 32'hffff_fff0, 0);
    add_test("addi_pos", enc_i(12'h123, 3'd0, `XIF_OPC_CUSTOM1), 32'd100, 32'd0, 0);
    add_test("addi_minus1", enc_i(12'hfff, 3'd0, `XIF_OPC_CUSTOM1), 32'd0, 32'd0, 0);
    add_test("addi_min", enc_i(12'h800, 3'd0, `XIF_OPC_CUSTOM1), 32'd1000, 32'd0, 0);
    add_test("slli_31", enc_i(12'h01f, 3'd1, `XIF_OPC_CUSTOM1), 32'd1, 32'd0, 0);
    add_test("slli_4", enc_i(12'h004, 3'd1, `XIF_OPC_CUSTOM1), 32'h0000_000f, 32'd0, 0);
    add_test("slli_upper", enc_i(12'h021, 3'd1, `XIF_OPC_CUSTOM1), 32'd1, 32'd0, 0);
    add_test("bad_opcode", enc_r(7'd0, 3'd0, 7'b0110011), 32'd1, 32'd2, 0);
    add_test("bad_funct7", enc_r(7'h20, 3'd0, `XIF_OPC_CUSTOM0), 32'd1, 32'd2, 0);
    add_test("bad_funct3_r", enc_r(7'd0, 3'd4, `XIF_OPC_CUSTOM0), 32'd1, 32'd2, 0);
    add_test("bad_funct3_i", enc_i(12'h001, 3'd2, `XIF_OPC_CUSTOM1), 32'd1, 32'd2, 0);
    add_test("hold_add", enc_r(7'd0, 3'd0, `XIF_OPC_CUSTOM0), 32'd40, 32'd2, 4);
    add_test("hold_illegal", enc_r(7'd1, 3'd2, `XIF_OPC_CUSTOM0), 32'd3, 32'd4, 3);
    // Random mix of legal and illegal encodings with random operands
    for (int k = 0; k < 16; k++) begin
      word = $random(seed);
      case ($unsigned($random(seed)) % 4)
        0: begin
          word[6:0]   = `XIF_OPC_CUSTOM0;
          word[31:25] = 7'd0;
        end
        1: word[6:0] = `XIF_OPC_CUSTOM0;
        2: begin
          word[6:0] = `XIF_OPC_CUSTOM1;
          word[14]  = 1'b0;
          if (word[31]) begin
            word[31:25] = 7'd0;
          end
        end
        default: ;
      endcase
      add_test($sformatf("random_%0d", k), word, $random(seed), $random(seed), k % 3);
    end
  endtask

  task automatic run_test(input test_entry_t t);
    xif_pkg::host_rsp_t exp;
    int                 cycles;
    bit                 ok;
    ok  = 1'b1;
    exp = ref_model(t.instr, t.rs1, t.rs2);
    host_req_data.instr <= t.instr;
    host_req_data.rs1   <= t.rs1;
    host_req_data.rs2   <= t.rs2;
    host_req            <= 1'b1;
    cycles = 0;
    while (!host_ack && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    assert (host_ack) else begin
      $display("Test %s timed out waiting for the ack to rise", t.name);
      errors++;
      timed_out = 1'b1;
    end
    if (timed_out) begin
      return;
    end
    assert (host_rsp === exp) else begin
      $display("FAIL %s expected result=%h illegal=%b actual result=%h illegal=%b",
               t.name, exp.result, exp.illegal, host_rsp.result, host_rsp.illegal);
      errors++;
      ok = 1'b0;
    end
    // Extra cycles with req still high, ack must stay up
    repeat (t.hold) begin
      @(posedge clk);
      assert (host_ack) else begin
        $display("Test %s lost the ack while the request was still held", t.name);
        errors++;
        ok = 1'b0;
      end
    end
    host_req <= 1'b0;
    cycles = 0;
    while (host_ack && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    assert (!host_ack) else begin
      $display("Test %s timed out waiting for the ack to fall", t.name);
      errors++;
      timed_out = 1'b1;
      ok = 1'b0;
    end
    run_count++;
    if (ok) begin
      pass_count++;
      $display("PASS %s result=%h illegal=%b", t.name, host_rsp.result, host_rsp.illegal);
    end
  endtask

  initial begin
    seed          = 32'h17b7_1d3f;
    errors        = 0;
    run_count     = 0;
    pass_count    = 0;
    timed_out     = 1'b0;
    rst_n         = 1'b0;
    host_req      = 1'b0;
    host_req_data = '0;
    build_table();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    foreach (tests[n]) begin
      if (!timed_out) begin
        run_test(tests[n]);
      end
    end
    $display("Tests run: %0d, passed: %0d, errors: %0d", run_count, pass_count, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== test/cpu_subsys_properties.sv ====
`timescale 1ns/1ps

`include "xif_defs.svh"

module cpu_subsys_properties (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 host_req_i,
  input logic                 host_ack_i,
  input logic                 issue_valid_i,
  input logic                 issue_ready_i,
  input logic [31:0]          instr_i,
  input logic                 result_valid_i,
  input logic                 result_ready_i,
  input logic [`XIF_XLEN-1:0] result_i
);

  // Ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(host_ack_i) |-> host_req_i)
    else $error("host ack rose without a host request");

  ack_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_ack_i && host_req_i |=> host_ack_i)
    else $error("host ack dropped before the request was released");

  // Issue channel keeps its offer until the coprocessor is ready
  issue_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_i && !issue_ready_i |=> issue_valid_i && $stable(instr_i))
    else $error("issue offer withdrawn or changed before issue ready");

  result_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_i))
    else $error("result withdrawn or changed before result ready");

  // First cycle out of reset starts quiet
  quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !host_ack_i && !issue_valid_i && !result_valid_i)
    else $error("ack or a valid is high right after reset");

endmodule

bind cpu_subsys cpu_subsys_properties i_cpu_subsys_properties (
  .clk_i          ( clk_i                 ),
  .rst_n_i        ( rst_n_i               ),
  .host_req_i     ( host_req_i            ),
  .host_ack_i     ( host_ack_o            ),
  .issue_valid_i  ( xif_req.issue_valid   ),
  .issue_ready_i  ( xif_resp.issue_ready  ),
  .instr_i        ( xif_req.instr         ),
  .result_valid_i ( xif_resp.result_valid ),
  .result_ready_i ( xif_req.result_ready  ),
  .result_i       ( xif_resp.result       )
);

// ==== hdl/cpu_subsys.sv ====
`timescale 1ns/1ps

`include "xif_defs.svh"

module cpu_subsys (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               host_req_i,
  input  xif_pkg::host_req_t host_req_data_i,
  output logic               host_ack_o,
  output xif_pkg::host_rsp_t host_rsp_o
);

  // Extension interface between issuer and coprocessor
  xif_pkg::xif_req_t  xif_req;
  xif_pkg::xif_resp_t xif_resp;

  offload_unit i_offload_unit (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .host_req_i      ( host_req_i      ),
    .host_req_data_i ( host_req_data_i ),
    .host_ack_o      ( host_ack_o      ),
    .host_rsp_o      ( host_rsp_o      ),
    .xif_req_o       ( xif_req         ),
    .xif_resp_i      ( xif_resp        )
  );

  if (`XIF_COPRO_EN) begin : gen_coprocessor
    xif_coprocessor i_xif_coprocessor (
      .clk_i      ( clk_i    ),
      .rst_n_i    ( rst_n_i  ),
      .xif_req_i  ( xif_req  ),
      .xif_resp_o ( xif_resp )
    );
  end else begin : gen_fixed_responder
    // Always ready, never accepts, so every instruction comes back illegal
    always_comb begin
      xif_resp             = '0;
      xif_resp.issue_ready = 1'b1;
    end
  end

endmodule

// ==== hdl/offload_unit.sv ====
`timescale 1ns/1ps

module offload_unit (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               host_req_i,
  input  xif_pkg::host_req_t host_req_data_i,
  output logic               host_ack_o,
  output xif_pkg::host_rsp_t host_rsp_o,
  output xif_pkg::xif_req_t  xif_req_o,
  input  xif_pkg::xif_resp_t xif_resp_i
);

  typedef enum logic [2:0] {
    IDLE,
    ISSUE,
    WAIT_RESULT,
    ACK,
    RELEASE
  } state_e;

  state_e             state_q;
  state_e             state_d;
  xif_pkg::host_req_t req_q;
  xif_pkg::host_rsp_t rsp_q;

  logic capture;
  logic issue_fire;
  logic result_fire;

  // New host request seen while idle
  assign capture     = (state_q == IDLE) && host_req_i;
  // Issue and result handshakes
  assign issue_fire  = (state_q == ISSUE) && xif_resp_i.issue_ready;
  assign result_fire = (state_q == WAIT_RESULT) && xif_resp_i.result_valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (host_req_i) begin
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        if (issue_fire) begin
          // Rejected instructions skip the result phase
          state_d = xif_resp_i.accept ? WAIT_RESULT : ACK;
        end
      end
      WAIT_RESULT: begin
        if (result_fire) begin
          state_d = ACK;
        end
      end
      ACK: begin
        // Ack stays up for as long as the host holds req
        if (!host_req_i) begin
          state_d = RELEASE;
        end
      end
      RELEASE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (capture) begin
      req_q <= host_req_data_i;
    end
    if (issue_fire && !xif_resp_i.accept) begin
      rsp_q.result  <= '0;
      rsp_q.illegal <= 1'b1;
    end else if (result_fire) begin
      rsp_q.result  <= xif_resp_i.result;
      rsp_q.illegal <= 1'b0;
    end
  end

  // Instruction and operands come from the captured request and stay stable
  always_comb begin
    xif_req_o.issue_valid  = (state_q == ISSUE);
    xif_req_o.instr        = req_q.instr;
    xif_req_o.rs1          = req_q.rs1;
    xif_req_o.rs2          = req_q.rs2;
    xif_req_o.result_ready = (state_q == WAIT_RESULT);
  end

  assign host_ack_o = (state_q == ACK);
  assign host_rsp_o = rsp_q;

endmodule

// ==== copro/xif_coprocessor.sv ====
`timescale 1ns/1ps

`include "xif_defs.svh"

module xif_coprocessor (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  xif_pkg::xif_req_t  xif_req_i,
  output xif_pkg::xif_resp_t xif_resp_o
);

  logic                 accept;
  xif_pkg::copro_op_e   op;
  logic                 use_imm;
  logic [`XIF_XLEN-1:0] imm;
  logic [`XIF_XLEN-1:0] operand_b;
  logic                 issue_ready;
  logic                 start;
  logic                 result_valid;
  logic [`XIF_XLEN-1:0] result;

  copro_decoder i_copro_decoder (
    .instr_i   ( xif_req_i.instr ),
    .accept_o  ( accept          ),
    .op_o      ( op              ),
    .use_imm_o ( use_imm         ),
    .imm_o     ( imm             )
  );

  // Ready only while the result buffer is empty
  assign issue_ready = ~result_valid;
  // Only accepted issues start the ALU
  assign start       = xif_req_i.issue_valid & issue_ready & accept;
  assign operand_b   = use_imm ? imm : xif_req_i.rs2;

  copro_alu i_copro_alu (
    .clk_i          ( clk_i                  ),
    .rst_n_i        ( rst_n_i                ),
    .start_i        ( start                  ),
    .op_i           ( op                     ),
    .a_i            ( xif_req_i.rs1          ),
    .b_i            ( operand_b              ),
    .result_ready_i ( xif_req_i.result_ready ),
    .result_valid_o ( result_valid           ),
    .result_o       ( result                 )
  );

  always_comb begin
    xif_resp_o.issue_ready  = issue_ready;
    xif_resp_o.accept       = accept;
    xif_resp_o.result_valid = result_valid;
    xif_resp_o.result       = result;
  end

endmodule

// ==== copro/copro_alu.sv ====
`timescale 1ns/1ps

`include "xif_defs.svh"

module copro_alu (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 start_i,
  input  xif_pkg::copro_op_e   op_i,
  input  logic [`XIF_XLEN-1:0] a_i,
  input  logic [`XIF_XLEN-1:0] b_i,
  input  logic                 result_ready_i,
  output logic                 result_valid_o,
  output logic [`XIF_XLEN-1:0] result_o
);

  logic [`XIF_XLEN-1:0] alu_out;
  logic [`XIF_XLEN-1:0] result_q;
  logic                 valid_q;

  // All arithmetic wraps modulo 2^XLEN
  always_comb begin
    case (op_i)
      xif_pkg::OP_ADD:  alu_out = a_i + b_i;
      xif_pkg::OP_SUB:  alu_out = a_i - b_i;
      xif_pkg::OP_XOR:  alu_out = a_i ^ b_i;
      xif_pkg::OP_MINU: alu_out = (a_i < b_i) ? a_i : b_i;
      // Shift amount from the low five bits only
      xif_pkg::OP_SLL:  alu_out = a_i << b_i[4:0];
      default:          alu_out = '0;
    endcase
  end

  // One-entry result buffer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (start_i) begin
      valid_q <= 1'b1;
    end else if (valid_q && result_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      result_q <= alu_out;
    end
  end

  assign result_valid_o = valid_q;
  assign result_o       = result_q;

endmodule

// ==== copro/copro_decoder.sv ====
`timescale 1ns/1ps

`include "xif_defs.svh"

module copro_decoder (
  input  xif_pkg::xif_instr_u  instr_i,
  output logic                 accept_o,
  output xif_pkg::copro_op_e   op_o,
  output logic                 use_imm_o,
  output logic [`XIF_XLEN-1:0] imm_o
);

  always_comb begin
    accept_o  = 1'b0;
    op_o      = xif_pkg::OP_ADD;
    use_imm_o = 1'b0;
    imm_o     = '0;

    // Opcode sits in the same place in both views
    case (instr_i.r.opcode)
      `XIF_OPC_CUSTOM0: begin
        if (instr_i.r.funct7 == 7'd0) begin
          accept_o = 1'b1;
          case (instr_i.r.funct3)
            3'd0: op_o = xif_pkg::OP_ADD;
            3'd1: op_o = xif_pkg::OP_SUB;
            3'd2: op_o = xif_pkg::OP_XOR;
            3'd3: op_o = xif_pkg::OP_MINU;
            default: accept_o = 1'b0;
          endcase
        end
      end
      `XIF_OPC_CUSTOM1: begin
        use_imm_o = 1'b1;
        case (instr_i.i.funct3)
          3'd0: begin
            // Add-immediate, sign-extended
            accept_o = 1'b1;
            op_o     = xif_pkg::OP_ADD;
            imm_o    = {{(`XIF_XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
          end
          3'd1: begin
            // Shift-left takes only a 5-bit amount, upper bits must be clear
            if (instr_i.i.imm[11:5] == 7'd0) begin
              accept_o = 1'b1;
              op_o     = xif_pkg::OP_SLL;
              imm_o    = {{(`XIF_XLEN-5){1'b0}}, instr_i.i.imm[4:0]};
            end
          end
          default: accept_o = 1'b0;
        endcase
      end
      default: accept_o = 1'b0;
    endcase
  end

endmodule

// ==== common/xif_pkg.sv ====
`include "xif_defs.svh"

package xif_pkg;

  // R-type view of an instruction word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } xif_instr_r_t;

  // I-type view of an instruction word
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } xif_instr_i_t;

  // Same 32-bit word, decoded either way
  typedef union packed {
    xif_instr_r_t r;
    xif_instr_i_t i;
  } xif_instr_u;

  // Operations understood by the coprocessor ALU
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_XOR  = 3'd2,
    OP_MINU = 3'd3,
    OP_SLL  = 3'd4
  } copro_op_e;

  // Host request, instruction plus both operands
  typedef struct packed {
    xif_instr_u            instr;
    logic [`XIF_XLEN-1:0] rs1;
    logic [`XIF_XLEN-1:0] rs2;
  } host_req_t;

  typedef struct packed {
    logic [`XIF_XLEN-1:0] result;
    logic                 illegal;
  } host_rsp_t;

  // Issuer towards coprocessor
  typedef struct packed {
    logic                 issue_valid;
    xif_instr_u           instr;
    logic [`XIF_XLEN-1:0] rs1;
    logic [`XIF_XLEN-1:0] rs2;
    logic                 result_ready;
  } xif_req_t;

  // Coprocessor back towards issuer
  typedef struct packed {
    logic                 issue_ready;
    logic                 accept;
    logic                 result_valid;
    logic [`XIF_XLEN-1:0] result;
  } xif_resp_t;

endpackage

// ==== common/xif_defs.svh ====
`ifndef XIF_DEFS_SVH
`define XIF_DEFS_SVH

// Operand and result width
`define XIF_XLEN 32

// Major opcodes of the custom instruction spaces
// custom-0 carries R-type, custom-1 carries I-type
`define XIF_OPC_CUSTOM0 7'b0001011
`define XIF_OPC_CUSTOM1 7'b0101011

// Coprocessor present when 1
// Set to 0 to fall back to the fixed responder that rejects everything
`define XIF_COPRO_EN 1'b1

`endif
